//--- hw/xdma_config.svh
// widths, address map and queue depths of the dma adapter
`ifndef XDMA_CONFIG_SVH
`define XDMA_CONFIG_SVH

// ----------------------------------------------------------------------
// widths
// ----------------------------------------------------------------------
`define XDMA_ADDR_W 48
`define XDMA_DATA_W 64
`define XDMA_ID_W 4
`define XDMA_LEN_W 8
// spare bits left over in a grant word
`define XDMA_GRANT_RSV_W (`XDMA_DATA_W - `XDMA_ID_W - `XDMA_ADDR_W)

// ----------------------------------------------------------------------
// address map
// ----------------------------------------------------------------------
// clusters sit back to back from here
`define XDMA_CLUSTER_BASE 48'h0000_1000_0000
`define XDMA_CLUSTER_SPACE 48'h0000_0010_0000
// main memory runs up to 4 GiB
`define XDMA_MAIN_BASE 48'h0000_8000_0000
`define XDMA_MAIN_END 48'h0001_0000_0000
// one mailbox window per slot, 16 KiB each
`define XDMA_MMIO_WINDOW 48'h0000_0000_4000

// queue depths
`define XDMA_DATA_DEPTH 4
`define XDMA_GRANT_DEPTH 2

`endif

//--- hw/xdma_pkg.sv
// dma adapter types, grant word union and mailbox window functions
`include "xdma_config.svh"

package xdma_pkg;

  typedef logic [`XDMA_ADDR_W-1:0] addr_t;
  typedef logic [`XDMA_DATA_W-1:0] data_t;
  typedef logic [`XDMA_ID_W-1:0] dma_id_t;
  typedef logic [`XDMA_LEN_W-1:0] len_t;

  // mailbox slots, counted down from the end of a region
  typedef enum logic [1:0] {
    SLOT_DATA  = 2'd0,
    SLOT_CFG   = 2'd1,
    SLOT_GRANT = 2'd2
  } slot_e;

  // grant as seen on the wire, msb first
  typedef struct packed {
    dma_id_t                      dma_id;
    addr_t                        from_addr;
    logic [`XDMA_GRANT_RSV_W-1:0] reserved;
  } grant_s;

  // one word, raw or as grant fields
  typedef union packed {
    data_t  raw;
    grant_s grant;
  } word_u;

  // one outbound transfer toward a remote window
  typedef struct packed {
    dma_id_t dma_id;
    addr_t   remote_addr;
    len_t    length;
  } remote_desc_s;

  // end of the region that holds a remote target
  function automatic addr_t remote_end(input addr_t target);
    addr_t idx;
    idx = (target - `XDMA_CLUSTER_BASE) / `XDMA_CLUSTER_SPACE;
    if (target >= `XDMA_MAIN_BASE) begin
      return `XDMA_MAIN_END;
    end
    return `XDMA_CLUSTER_BASE + (idx + 1'b1) * `XDMA_CLUSTER_SPACE;
  endfunction

  // start of a slot window below a region end
  function automatic addr_t window_base(input addr_t end_addr, input slot_e slot);
    return end_addr - (addr_t'(slot) + 1'b1) * `XDMA_MMIO_WINDOW;
  endfunction

endpackage

//--- hw/xdma_desc_if.sv
// descriptor bundle between the descriptor builder and the write arbiter
`timescale 1ns/1ps

interface xdma_desc_if;

  // ----------------------------------------------------------------------
  // remote descriptors, one per outbound source
  // ----------------------------------------------------------------------
  // config word toward the remote cfg window
  xdma_pkg::remote_desc_s cfg_desc;
  // data beats toward the remote data window
  xdma_pkg::remote_desc_s data_desc;
  // grant back to the sender of inbound data
  xdma_pkg::remote_desc_s grant_desc;

  // grant payload, already packed
  xdma_pkg::word_u grant_word;

  // all level signals, no handshake
  // values track the sender inputs every cycle

  // builder side produces everything
  modport builder (
    output cfg_desc,
    output data_desc,
    output grant_desc,
    output grant_word
  );

  // arbiter side only looks
  modport arbiter (
    input cfg_desc,
    input data_desc,
    input grant_desc,
    input grant_word
  );

endinterface

//--- hw/xdma_desc_builder.sv
// descriptor builder: remote mailbox addresses and grant word packing
`timescale 1ns/1ps

module xdma_desc_builder (
  // config source
  input  xdma_pkg::dma_id_t cfg_dma_id_i,
  input  logic              cfg_dma_type_i,
  input  xdma_pkg::addr_t   cfg_reader_addr_i,
  input  xdma_pkg::addr_t   cfg_writer_addr_i,
  // data source
  input  xdma_pkg::dma_id_t data_dma_id_i,
  input  xdma_pkg::addr_t   data_dst_addr_i,
  input  xdma_pkg::len_t    data_len_i,
  // inbound transfer that needs a grant
  input  xdma_pkg::dma_id_t rx_dma_id_i,
  input  xdma_pkg::addr_t   rx_src_addr_i,
  xdma_desc_if.builder      desc
);

  // remote side of the config transfer
  xdma_pkg::addr_t cfg_target;

  always_comb begin
    // type 0 reads: remote is the reader
    // type 1 writes: remote is the writer
    cfg_target = cfg_dma_type_i ? cfg_writer_addr_i : cfg_reader_addr_i;

    // ----------------------------------------------------------------------
    // config descriptor
    // ----------------------------------------------------------------------
    desc.cfg_desc.dma_id      = cfg_dma_id_i;
    desc.cfg_desc.remote_addr = xdma_pkg::window_base(xdma_pkg::remote_end(cfg_target),
                                                      xdma_pkg::SLOT_CFG);
    // single word
    desc.cfg_desc.length      = xdma_pkg::len_t'(1);

    // ----------------------------------------------------------------------
    // data descriptor
    // ----------------------------------------------------------------------
    desc.data_desc.dma_id      = data_dma_id_i;
    desc.data_desc.remote_addr = xdma_pkg::window_base(xdma_pkg::remote_end(data_dst_addr_i),
                                                       xdma_pkg::SLOT_DATA);
    desc.data_desc.length      = data_len_i;

    // ----------------------------------------------------------------------
    // grant descriptor, sent back to the data source
    // ----------------------------------------------------------------------
    desc.grant_desc.dma_id      = rx_dma_id_i;
    desc.grant_desc.remote_addr = xdma_pkg::window_base(xdma_pkg::remote_end(rx_src_addr_i),
                                                        xdma_pkg::SLOT_GRANT);
    desc.grant_desc.length      = xdma_pkg::len_t'(1);

    // grant payload through the union view
    desc.grant_word.grant.dma_id    = rx_dma_id_i;
    desc.grant_word.grant.from_addr = rx_src_addr_i;
    desc.grant_word.grant.reserved  = '0;
  end

endmodule

//--- hw/xdma_word_fifo.sv
// small synchronous fifo of data words with occupancy count
`timescale 1ns/1ps

module xdma_word_fifo #(
  parameter int DEPTH = 4
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            push_i,
  input  xdma_pkg::data_t push_data_i,
  input  logic            pop_i,
  output xdma_pkg::data_t head_o,
  output logic            empty_o,
  output logic            full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  xdma_pkg::data_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic do_push;
  logic do_pop;

  // overflow and underflow are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign head_o  = mem[rd_ptr_q];

  // pointers wrap at DEPTH, not at a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

//--- hw/xdma_write_arbiter.sv
// write arbiter: source priority, grant gating and data beat counter
`timescale 1ns/1ps

module xdma_write_arbiter (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            cfg_stb_i,
  input  xdma_pkg::data_t cfg_word_i,
  input  logic            grant_stb_i,
  xdma_desc_if.arbiter    desc,
  // data queue
  input  xdma_pkg::data_t data_head_i,
  input  logic            data_empty_i,
  output logic            data_pop_o,
  // grant queue
  input  xdma_pkg::word_u grant_head_i,
  input  logic            grant_empty_i,
  output logic            grant_pop_o,
  // outbound write
  output logic            wr_stb_o,
  output xdma_pkg::addr_t wr_addr_o,
  output xdma_pkg::data_t wr_data_o,
  output logic            tx_done_o
);

  logic            cfg_pend_q;
  logic            grant_pend_q;
  xdma_pkg::data_t cfg_word_q;
  xdma_pkg::len_t  beat_cnt_q;
  logic            cfg_req;
  logic            data_ok;
  logic            sel_grant;
  logic            sel_cfg;
  logic            sel_data;
  logic            last_beat;
  xdma_pkg::data_t cfg_data;
  xdma_pkg::addr_t nxt_addr;
  xdma_pkg::data_t nxt_data;

  // ----------------------------------------------------------------------
  // source select: grant, then config, then data
  // ----------------------------------------------------------------------
  always_comb begin
    // config may leave in its strobe cycle, newest word wins
    cfg_req  = cfg_stb_i || cfg_pend_q;
    cfg_data = cfg_stb_i ? cfg_word_i : cfg_word_q;
    // data only under a matching grant
    // hold off while the finished grant is popped
    data_ok  = !data_empty_i && !grant_empty_i && !tx_done_o &&
               (grant_head_i.grant.dma_id == desc.data_desc.dma_id);
    sel_grant = grant_pend_q;
    sel_cfg   = !grant_pend_q && cfg_req;
    sel_data  = !grant_pend_q && !cfg_req && data_ok;
    last_beat = sel_data &&
                (xdma_pkg::len_t'(beat_cnt_q + 1'b1) == desc.data_desc.length);
    nxt_addr = desc.data_desc.remote_addr;
    nxt_data = data_head_i;
    if (sel_grant) begin
      nxt_addr = desc.grant_desc.remote_addr;
      nxt_data = desc.grant_word.raw;
    end else if (sel_cfg) begin
      nxt_addr = desc.cfg_desc.remote_addr;
      nxt_data = cfg_data;
    end
  end

  assign data_pop_o  = sel_data;
  // grant retires together with the done pulse
  assign grant_pop_o = tx_done_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_pend_q   <= 1'b0;
      grant_pend_q <= 1'b0;
      beat_cnt_q   <= '0;
      wr_stb_o     <= 1'b0;
      tx_done_o    <= 1'b0;
    end else begin
      cfg_pend_q   <= cfg_req && !sel_cfg;
      // top priority, so the flag lasts one cycle
      grant_pend_q <= grant_stb_i;
      if (sel_data) begin
        beat_cnt_q <= last_beat ? '0 : beat_cnt_q + 1'b1;
      end
      wr_stb_o  <= sel_grant || sel_cfg || sel_data;
      tx_done_o <= last_beat;
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (cfg_stb_i) begin
      cfg_word_q <= cfg_word_i;
    end
    wr_addr_o <= nxt_addr;
    wr_data_o <= nxt_data;
  end

endmodule

//--- hw/xdma_rx_demux.sv
// inbound write decoder against the local mailbox windows
`timescale 1ns/1ps
`include "xdma_config.svh"

module xdma_rx_demux (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  xdma_pkg::addr_t cluster_base_addr_i,
  // inbound write
  input  logic            in_stb_i,
  input  xdma_pkg::addr_t in_addr_i,
  input  xdma_pkg::data_t in_data_i,
  // decoded outputs
  output logic            rx_cfg_stb_o,
  output xdma_pkg::data_t rx_cfg_o,
  output logic            rx_data_stb_o,
  output xdma_pkg::data_t rx_data_o,
  output logic            grant_push_o,
  output xdma_pkg::data_t grant_word_o
);

  xdma_pkg::addr_t local_end;
  xdma_pkg::addr_t data_base;
  xdma_pkg::addr_t cfg_base;
  xdma_pkg::addr_t grant_base;
  logic            hit_data;
  logic            hit_cfg;
  logic            hit_grant;
  xdma_pkg::data_t word_q;

  // half open window [base, base + window)
  function automatic logic in_window(input xdma_pkg::addr_t addr, input xdma_pkg::addr_t base);
    return (addr >= base) && (addr < base + `XDMA_MMIO_WINDOW);
  endfunction

  // ----------------------------------------------------------------------
  // local windows, same rule as the remote ones
  // ----------------------------------------------------------------------
  always_comb begin
    // main memory owns its own top of region
    local_end = (cluster_base_addr_i == `XDMA_MAIN_BASE) ? `XDMA_MAIN_END :
                cluster_base_addr_i + `XDMA_CLUSTER_SPACE;
    data_base  = xdma_pkg::window_base(local_end, xdma_pkg::SLOT_DATA);
    cfg_base   = xdma_pkg::window_base(local_end, xdma_pkg::SLOT_CFG);
    grant_base = xdma_pkg::window_base(local_end, xdma_pkg::SLOT_GRANT);
    // windows are disjoint, one hit at most
    hit_data  = in_stb_i && in_window(in_addr_i, data_base);
    hit_cfg   = in_stb_i && in_window(in_addr_i, cfg_base);
    hit_grant = in_stb_i && in_window(in_addr_i, grant_base);
  end

  // one strobe per decoded write, misses dropped
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_data_stb_o <= 1'b0;
      rx_cfg_stb_o  <= 1'b0;
      grant_push_o  <= 1'b0;
    end else begin
      rx_data_stb_o <= hit_data;
      rx_cfg_stb_o  <= hit_cfg;
      grant_push_o  <= hit_grant;
    end
  end

  // shared word register for all three outputs
  always_ff @(posedge clk_i) begin
    if (in_stb_i) begin
      word_q <= in_data_i;
    end
  end

  assign rx_data_o    = word_q;
  assign rx_cfg_o     = word_q;
  assign grant_word_o = word_q;

endmodule

//--- hw/xdma_adapter_top.sv
// dma adapter top: builder, arbiter, inbound decoder and the two queues
`timescale 1ns/1ps
`include "xdma_config.svh"

module xdma_adapter_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  xdma_pkg::addr_t   cluster_base_addr_i,
  // outbound config
  input  logic              cfg_stb_i,
  input  xdma_pkg::data_t   cfg_word_i,
  input  xdma_pkg::dma_id_t cfg_dma_id_i,
  input  logic              cfg_dma_type_i,
  input  xdma_pkg::addr_t   cfg_reader_addr_i,
  input  xdma_pkg::addr_t   cfg_writer_addr_i,
  // outbound data
  input  logic              data_stb_i,
  input  xdma_pkg::data_t   data_word_i,
  input  xdma_pkg::dma_id_t data_dma_id_i,
  input  xdma_pkg::addr_t   data_dst_addr_i,
  input  xdma_pkg::len_t    data_len_i,
  // outbound grant
  input  logic              grant_stb_i,
  input  xdma_pkg::dma_id_t rx_dma_id_i,
  input  xdma_pkg::addr_t   rx_src_addr_i,
  // outbound write port
  output logic              wr_stb_o,
  output xdma_pkg::addr_t   wr_addr_o,
  output xdma_pkg::data_t   wr_data_o,
  output logic              tx_done_o,
  // inbound write port
  input  logic              in_stb_i,
  input  xdma_pkg::addr_t   in_addr_i,
  input  xdma_pkg::data_t   in_data_i,
  output logic              rx_cfg_stb_o,
  output xdma_pkg::data_t   rx_cfg_o,
  output logic              rx_data_stb_o,
  output xdma_pkg::data_t   rx_data_o
);

  xdma_desc_if desc_if ();

  xdma_pkg::data_t data_head;
  logic            data_empty;
  logic            data_pop;
  xdma_pkg::data_t grant_head;
  logic            grant_empty;
  logic            grant_pop;
  logic            grant_push;
  xdma_pkg::data_t grant_word;

  // ----------------------------------------------------------------------
  // outbound path
  // ----------------------------------------------------------------------
  xdma_desc_builder i_desc_builder (
    .cfg_dma_id_i      (cfg_dma_id_i),
    .cfg_dma_type_i    (cfg_dma_type_i),
    .cfg_reader_addr_i (cfg_reader_addr_i),
    .cfg_writer_addr_i (cfg_writer_addr_i),
    .data_dma_id_i     (data_dma_id_i),
    .data_dst_addr_i   (data_dst_addr_i),
    .data_len_i        (data_len_i),
    .rx_dma_id_i       (rx_dma_id_i),
    .rx_src_addr_i     (rx_src_addr_i),
    .desc              (desc_if.builder)
  );

  // full flag unused, sender stays within depth
  xdma_word_fifo #(.DEPTH(`XDMA_DATA_DEPTH)) i_data_queue (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (data_stb_i),
    .push_data_i (data_word_i),
    .pop_i       (data_pop),
    .head_o      (data_head),
    .empty_o     (data_empty),
    .full_o      ()
  );

  xdma_write_arbiter i_write_arbiter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cfg_stb_i     (cfg_stb_i),
    .cfg_word_i    (cfg_word_i),
    .grant_stb_i   (grant_stb_i),
    .desc          (desc_if.arbiter),
    .data_head_i   (data_head),
    .data_empty_i  (data_empty),
    .data_pop_o    (data_pop),
    .grant_head_i  (grant_head),
    .grant_empty_i (grant_empty),
    .grant_pop_o   (grant_pop),
    .wr_stb_o      (wr_stb_o),
    .wr_addr_o     (wr_addr_o),
    .wr_data_o     (wr_data_o),
    .tx_done_o     (tx_done_o)
  );

  // ----------------------------------------------------------------------
  // inbound path
  // ----------------------------------------------------------------------
  xdma_rx_demux i_rx_demux (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .cluster_base_addr_i (cluster_base_addr_i),
    .in_stb_i            (in_stb_i),
    .in_addr_i           (in_addr_i),
    .in_data_i           (in_data_i),
    .rx_cfg_stb_o        (rx_cfg_stb_o),
    .rx_cfg_o            (rx_cfg_o),
    .rx_data_stb_o       (rx_data_stb_o),
    .rx_data_o           (rx_data_o),
    .grant_push_o        (grant_push),
    .grant_word_o        (grant_word)
  );

  // received grants wait here for the data they unlock
  xdma_word_fifo #(.DEPTH(`XDMA_GRANT_DEPTH)) i_grant_queue (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (grant_push),
    .push_data_i (grant_word),
    .pop_i       (grant_pop),
    .head_o      (grant_head),
    .empty_o     (grant_empty),
    .full_o      ()
  );

endmodule

//--- sim/xdma_adapter_props.sv
// concurrent properties of the dma adapter top and their bind
`timescale 1ns/1ps
`include "xdma_config.svh"

module xdma_adapter_props (
  input logic            clk_i,
  input logic            rst_n_i,
  input xdma_pkg::addr_t cluster_base_addr_i,
  input logic            in_stb_i,
  input xdma_pkg::addr_t in_addr_i,
  input logic            rx_cfg_stb_i,
  input logic            rx_data_stb_i,
  input logic            wr_stb_i,
  input logic            tx_done_i
);

  // read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  xdma_pkg::addr_t region_end;
  xdma_pkg::addr_t data_lo;
  xdma_pkg::addr_t cfg_lo;
  logic            hit_data;
  logic            hit_cfg;

  // ----------------------------------------------------------------------
  // local windows, data on top, cfg right below
  // ----------------------------------------------------------------------
  always_comb begin
    region_end = (cluster_base_addr_i == `XDMA_MAIN_BASE) ? `XDMA_MAIN_END :
                 cluster_base_addr_i + `XDMA_CLUSTER_SPACE;
    data_lo  = region_end - `XDMA_MMIO_WINDOW;
    cfg_lo   = data_lo - `XDMA_MMIO_WINDOW;
    hit_data = in_stb_i && (in_addr_i >= data_lo) && (in_addr_i < region_end);
    hit_cfg  = in_stb_i && (in_addr_i >= cfg_lo) && (in_addr_i < data_lo);
  end

  // strobe exactly one cycle after a hit, never without one
  rx_data_follows_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_data_stb_i == $past(hit_data))
    else begin
      fail_cnt++;
      $error("rx_data_stb_o does not follow a data window write by one cycle");
    end

  rx_cfg_follows_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_cfg_stb_i == $past(hit_cfg))
    else begin
      fail_cnt++;
      $error("rx_cfg_stb_o does not follow a cfg window write by one cycle");
    end

  // windows are disjoint
  rx_strobes_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(rx_cfg_stb_i && rx_data_stb_i))
    else begin
      fail_cnt++;
      $error("rx_cfg_stb_o and rx_data_stb_o high in the same cycle");
    end

  done_with_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tx_done_i |-> wr_stb_i)
    else begin
      fail_cnt++;
      $error("tx_done_o without an outbound write");
    end

endmodule

bind xdma_adapter_top xdma_adapter_props i_props (
  .clk_i               (clk_i),
  .rst_n_i             (rst_n_i),
  .cluster_base_addr_i (cluster_base_addr_i),
  .in_stb_i            (in_stb_i),
  .in_addr_i           (in_addr_i),
  .rx_cfg_stb_i        (rx_cfg_stb_o),
  .rx_data_stb_i       (rx_data_stb_o),
  .wr_stb_i            (wr_stb_o),
  .tx_done_i           (tx_done_o)
);

//--- sim/xdma_adapter_tb.sv
// dma adapter testbench with clock, reset, stimulus, checks and summary
`timescale 1ns/1ps
`include "xdma_config.svh"

module xdma_adapter_tb;

  // whole run takes well under 300 cycles
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int WAIT_LIMIT = 20;
  // third cluster with its windows at 0x102f_4000 .. 0x1030_0000
  localparam xdma_pkg::addr_t LOCAL_BASE = `XDMA_CLUSTER_BASE + 2 * `XDMA_CLUSTER_SPACE;

  logic              clk;
  logic              rst_n;
  logic              cfg_stb;
  xdma_pkg::data_t   cfg_word;
  xdma_pkg::dma_id_t cfg_dma_id;
  logic              cfg_dma_type;
  xdma_pkg::addr_t   cfg_reader_addr;
  xdma_pkg::addr_t   cfg_writer_addr;
  logic              data_stb;
  xdma_pkg::data_t   data_word;
  xdma_pkg::dma_id_t data_dma_id;
  xdma_pkg::addr_t   data_dst_addr;
  xdma_pkg::len_t    data_len;
  logic              grant_stb;
  xdma_pkg::dma_id_t rx_dma_id;
  xdma_pkg::addr_t   rx_src_addr;
  logic              in_stb;
  xdma_pkg::addr_t   in_addr;
  xdma_pkg::data_t   in_data;
  logic              wr_stb;
  xdma_pkg::addr_t   wr_addr;
  xdma_pkg::data_t   wr_data;
  logic              tx_done;
  logic              rx_cfg_stb;
  xdma_pkg::data_t   rx_cfg;
  logic              rx_data_stb;
  xdma_pkg::data_t   rx_data;

  int              errors;
  int              cycle_cnt;
  logic [15:0]     lfsr_state;
  xdma_pkg::data_t sent_words[$];

  xdma_adapter_top dut0 (
    .clk_i               (clk),
    .rst_n_i             (rst_n),
    .cluster_base_addr_i (LOCAL_BASE),
    .cfg_stb_i           (cfg_stb),
    .cfg_word_i          (cfg_word),
    .cfg_dma_id_i        (cfg_dma_id),
    .cfg_dma_type_i      (cfg_dma_type),
    .cfg_reader_addr_i   (cfg_reader_addr),
    .cfg_writer_addr_i   (cfg_writer_addr),
    .data_stb_i          (data_stb),
    .data_word_i         (data_word),
    .data_dma_id_i       (data_dma_id),
    .data_dst_addr_i     (data_dst_addr),
    .data_len_i          (data_len),
    .grant_stb_i         (grant_stb),
    .rx_dma_id_i         (rx_dma_id),
    .rx_src_addr_i       (rx_src_addr),
    .wr_stb_o            (wr_stb),
    .wr_addr_o           (wr_addr),
    .wr_data_o           (wr_data),
    .tx_done_o           (tx_done),
    .in_stb_i            (in_stb),
    .in_addr_i           (in_addr),
    .in_data_i           (in_data),
    .rx_cfg_stb_o        (rx_cfg_stb),
    .rx_cfg_o            (rx_cfg),
    .rx_data_stb_o       (rx_data_stb),
    .rx_data_o           (rx_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // ----------------------------------------------------------------------
  // random source and reference address rule
  // ----------------------------------------------------------------------
  // 16 bit galois lfsr with taps 16 14 13 11
  function automatic xdma_pkg::data_t rand_bits(input int n);
    xdma_pkg::data_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic xdma_pkg::addr_t cluster_addr();
    return `XDMA_CLUSTER_BASE + xdma_pkg::addr_t'(rand_bits(3)) * `XDMA_CLUSTER_SPACE +
           xdma_pkg::addr_t'(rand_bits(20));
  endfunction

  function automatic xdma_pkg::addr_t main_addr();
    return `XDMA_MAIN_BASE + xdma_pkg::addr_t'(rand_bits(31));
  endfunction

  // 8 byte aligned offset inside one window
  function automatic xdma_pkg::addr_t window_offset();
    return xdma_pkg::addr_t'(rand_bits(11)) << 3;
  endfunction

  // slots count down from the region end with data at the top
  function automatic xdma_pkg::addr_t remote_window(input xdma_pkg::addr_t target, input int slot);
    xdma_pkg::addr_t top;
    xdma_pkg::addr_t idx;
    idx = (target - `XDMA_CLUSTER_BASE) / `XDMA_CLUSTER_SPACE;
    top = (target >= `XDMA_MAIN_BASE) ? `XDMA_MAIN_END :
          `XDMA_CLUSTER_BASE + (idx + 48'd1) * `XDMA_CLUSTER_SPACE;
    return top - xdma_pkg::addr_t'(slot + 1) * `XDMA_MMIO_WINDOW;
  endfunction

  function automatic xdma_pkg::addr_t local_window(input int slot);
    return LOCAL_BASE + `XDMA_CLUSTER_SPACE - xdma_pkg::addr_t'(slot + 1) * `XDMA_MMIO_WINDOW;
  endfunction

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      errors++;
      $display("Fail t=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      errors++;
      $display("Error at t=%0t: %s", $time, what);
    end
  endtask

  // no outbound write, no done, no rx strobe
  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      check_value("wr_stb_o", 64'd0, wr_stb);
      check_value("tx_done_o", 64'd0, tx_done);
      check_value("rx_cfg_stb_o", 64'd0, rx_cfg_stb);
      check_value("rx_data_stb_o", 64'd0, rx_data_stb);
      @(negedge clk);
    end
  endtask

  task automatic wait_write(output logic seen);
    int waited;
    waited = 0;
    while (!wr_stb && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    seen = wr_stb;
    check_true(seen, "no outbound write arrived within the wait limit");
  endtask

  task automatic expect_write(input xdma_pkg::addr_t exp_addr, input xdma_pkg::data_t exp_data,
                              input logic exp_done);
    logic seen;
    wait_write(seen);
    if (seen) begin
      check_value("wr_addr_o", exp_addr, wr_addr);
      check_value("wr_data_o", exp_data, wr_data);
      check_value("tx_done_o", exp_done, tx_done);
    end
    @(negedge clk);
  endtask

  // ----------------------------------------------------------------------
  // stimulus driven on the falling edge
  // ----------------------------------------------------------------------
  task automatic reset_dut();
    rst_n = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic send_inbound(input xdma_pkg::addr_t addr, input xdma_pkg::data_t word);
    in_stb  = 1'b1;
    in_addr = addr;
    in_data = word;
    @(negedge clk);
    in_stb = 1'b0;
  endtask

  task automatic push_words(input int count);
    repeat (count) begin
      data_word = rand_bits(64);
      sent_words.push_back(data_word);
      data_stb = 1'b1;
      @(negedge clk);
    end
    data_stb = 1'b0;
  endtask

  // config target is the reader for type 0 and the writer for type 1
  task automatic run_cfg_case(input logic dma_type, input logic to_main);
    xdma_pkg::addr_t target;
    xdma_pkg::addr_t other;
    xdma_pkg::data_t word;
    target = to_main ? main_addr() : cluster_addr();
    other  = to_main ? cluster_addr() : main_addr();
    word   = rand_bits(64);
    cfg_dma_id      = xdma_pkg::dma_id_t'(rand_bits(4));
    cfg_dma_type    = dma_type;
    cfg_reader_addr = dma_type ? other : target;
    cfg_writer_addr = dma_type ? target : other;
    cfg_word = word;
    cfg_stb  = 1'b1;
    @(negedge clk);
    cfg_stb  = 1'b0;
    cfg_word = '0;
    expect_write(remote_window(target, 1), word, 1'b0);
    // exactly one write
    expect_quiet(2);
  endtask

  task automatic run_grant_case(input logic to_main);
    xdma_pkg::word_u seen_word;
    logic            seen;
    rx_dma_id   = xdma_pkg::dma_id_t'(rand_bits(4));
    rx_src_addr = to_main ? main_addr() : cluster_addr();
    grant_stb   = 1'b1;
    @(negedge clk);
    grant_stb = 1'b0;
    wait_write(seen);
    if (seen) begin
      seen_word.raw = wr_data;
      check_value("wr_addr_o", remote_window(rx_src_addr, 2), wr_addr);
      check_value("wr_data_o.dma_id", rx_dma_id, seen_word.grant.dma_id);
      check_value("wr_data_o.from_addr", rx_src_addr, seen_word.grant.from_addr);
    end
    @(negedge clk);
    expect_quiet(2);
  endtask

  // words for id 5 stay queued under a grant for id 9
  task automatic run_blocked_data();
    xdma_pkg::word_u gw;
    data_dma_id   = 4'd5;
    data_len      = 8'd3;
    data_dst_addr = cluster_addr();
    sent_words.delete();
    push_words(3);
    expect_quiet(6);
    gw.raw = '0;
    gw.grant.dma_id    = 4'd9;
    gw.grant.from_addr = data_dst_addr;
    send_inbound(local_window(2) + window_offset(), gw.raw);
    expect_quiet(8);
  endtask

  task automatic run_granted_data();
    xdma_pkg::word_u gw;
    data_dma_id   = xdma_pkg::dma_id_t'(rand_bits(4));
    data_len      = 8'd4;
    data_dst_addr = main_addr();
    sent_words.delete();
    push_words(4);
    // nothing moves without a grant
    expect_quiet(6);
    gw.raw = '0;
    gw.grant.dma_id    = data_dma_id;
    gw.grant.from_addr = data_dst_addr;
    send_inbound(local_window(2) + window_offset(), gw.raw);
    for (int i = 0; i < 4; i++) begin
      expect_write(remote_window(data_dst_addr, 0), sent_words[i], i == 3);
    end
    expect_quiet(3);
    // the grant left with the last beat so a further word stays queued
    push_words(1);
    expect_quiet(4);
  endtask

  task automatic run_inbound();
    xdma_pkg::data_t word;
    word = rand_bits(64);
    send_inbound(local_window(0) + window_offset(), word);
    check_value("rx_data_stb_o", 64'd1, rx_data_stb);
    check_value("rx_data_o", word, rx_data);
    check_value("rx_cfg_stb_o", 64'd0, rx_cfg_stb);
    @(negedge clk);
    expect_quiet(1);
    word = rand_bits(64);
    send_inbound(local_window(1) + window_offset(), word);
    check_value("rx_cfg_stb_o", 64'd1, rx_cfg_stb);
    check_value("rx_cfg_o", word, rx_cfg);
    check_value("rx_data_stb_o", 64'd0, rx_data_stb);
    @(negedge clk);
    expect_quiet(1);
    // misses below the grant window, in the next cluster and in main memory
    send_inbound(local_window(2) - 48'd8, rand_bits(64));
    expect_quiet(2);
    send_inbound(LOCAL_BASE + `XDMA_CLUSTER_SPACE, rand_bits(64));
    expect_quiet(2);
    send_inbound(main_addr(), rand_bits(64));
    expect_quiet(2);
  endtask

  // ----------------------------------------------------------------------
  // watchdog and main sequence
  // ----------------------------------------------------------------------
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles without finishing, errors so far: %0d",
             cycle_cnt, errors);
    $display("Verification failed");
    $finish;
  end

  initial begin
    errors     = 0;
    lfsr_state = 16'd60;
    rst_n = 1'b0;
    cfg_stb = 1'b0;
    cfg_word = '0;
    cfg_dma_id = '0;
    cfg_dma_type = 1'b0;
    cfg_reader_addr = '0;
    cfg_writer_addr = '0;
    data_stb = 1'b0;
    data_word = '0;
    data_dma_id = '0;
    data_dst_addr = '0;
    data_len = '0;
    grant_stb = 1'b0;
    rx_dma_id = '0;
    rx_src_addr = '0;
    in_stb = 1'b0;
    in_addr = '0;
    in_data = '0;
    reset_dut();
    expect_quiet(4);
    run_cfg_case(1'b0, 1'b0);
    run_cfg_case(1'b0, 1'b1);
    run_cfg_case(1'b1, 1'b0);
    run_cfg_case(1'b1, 1'b1);
    run_grant_case(1'b0);
    run_grant_case(1'b1);
    run_blocked_data();
    // clears the stale grant and the queued words
    reset_dut();
    expect_quiet(4);
    run_granted_data();
    run_inbound();
    $display("errors: checks %0d, properties %0d", errors, dut0.i_props.fail_cnt);
    if (errors == 0 && dut0.i_props.fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- xdma_adapter.f
+incdir+hw
hw/xdma_pkg.sv
hw/xdma_desc_if.sv
hw/xdma_desc_builder.sv
hw/xdma_word_fifo.sv
hw/xdma_write_arbiter.sv
hw/xdma_rx_demux.sv
hw/xdma_adapter_top.sv
sim/xdma_adapter_props.sv
sim/xdma_adapter_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dma adapter testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module xdma_adapter_tb -f xdma_adapter.f -o xdma_adapter_sim

# allow more than one assertion error so the testbench reaches its summary
./obj_dir/xdma_adapter_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "Verification passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation ok"
